//--- aimbot_params.svh
`ifndef AIMBOT_PARAMS_SVH
`define AIMBOT_PARAMS_SVH

// Active video size, kept small so a frame simulates in a few thousand cycles.
`define AB_H_ACT 16
`define AB_V_ACT 8

// Boxes per axis in the overlay grid.
`define AB_N_BOX 2

// Outline colour in RGB565, pure green.
`define AB_BOX_COLOR 16'h07E0

// Index widths that match the frame size above.
`define AB_ROW_W 3
`define AB_COL_W 4

`endif

//--- aimbot_pkg.sv
package aimbot_pkg;

    // One RGB565 pixel, red in the top bits as the camera sends it.
    typedef struct packed {
        logic [4:0] r;
        logic [5:0] g;
        logic [4:0] b;
    } pixel_t;

    // One cycle of a video stream between blocks.
    typedef struct packed {
        logic   vsync;  // High during vertical blanking.
        logic   de;     // High for one active pixel.
        pixel_t pixel;
    } video_beat_t;

endpackage : aimbot_pkg

//--- aimbot_top.sv
`include "aimbot_params.svh"

module aimbot_top (
    input  logic                 i_clk,
    input  logic                 i_rst,
    input  logic                 i_cam1_vsync,
    input  logic                 i_cam1_href,
    input  logic [7:0]           i_cam1_data,
    input  logic                 i_cam2_vsync,
    input  logic                 i_cam2_href,
    input  logic [7:0]           i_cam2_data,
    input  logic                 i_box_en,
    input  logic                 i_cam_sel,
    input  logic                 i_px_ack,
    output logic                 o_hdmi_vsync,
    output logic                 o_hdmi_de,
    output logic [7:0]           o_hdmi_r,
    output logic [7:0]           o_hdmi_g,
    output logic [7:0]           o_hdmi_b,
    output logic                 o_cam_shown,
    output logic                 o_px_req,
    output aimbot_pkg::pixel_t   o_px_data,
    output logic                 o_px_cam,
    output logic [`AB_ROW_W-1:0] o_px_row,
    output logic                 o_px_last,
    output logic                 o_frame_err
);

    logic               cam1_vsync;
    logic               cam1_de;
    aimbot_pkg::pixel_t cam1_pixel;
    logic               cam2_vsync;
    logic               cam2_de;
    aimbot_pkg::pixel_t cam2_pixel;
    logic               ovl1_vsync;
    logic               ovl1_de;
    aimbot_pkg::pixel_t ovl1_pixel;
    logic               ovl2_vsync;
    logic               ovl2_de;
    aimbot_pkg::pixel_t ovl2_pixel;
    aimbot_pkg::pixel_t disp_pixel;

    cam_byte_assembler u_cam1_asm (
        .i_clk  (i_clk       ),
        .i_rst  (i_rst       ),
        .i_vsync(i_cam1_vsync),
        .i_href (i_cam1_href ),
        .i_data (i_cam1_data ),
        .o_vsync(cam1_vsync  ),
        .o_de   (cam1_de     ),
        .o_pixel(cam1_pixel  )
    );

    cam_byte_assembler u_cam2_asm (
        .i_clk  (i_clk       ),
        .i_rst  (i_rst       ),
        .i_vsync(i_cam2_vsync),
        .i_href (i_cam2_href ),
        .i_data (i_cam2_data ),
        .o_vsync(cam2_vsync  ),
        .o_de   (cam2_de     ),
        .o_pixel(cam2_pixel  )
    );

    box_overlay #(.N_BOX(`AB_N_BOX)) u_cam1_ovl (
        .i_clk  (i_clk     ),
        .i_rst  (i_rst     ),
        .i_en   (i_box_en  ),
        .i_vsync(cam1_vsync),
        .i_de   (cam1_de   ),
        .i_pixel(cam1_pixel),
        .o_vsync(ovl1_vsync),
        .o_de   (ovl1_de   ),
        .o_pixel(ovl1_pixel)
    );

    box_overlay #(.N_BOX(`AB_N_BOX)) u_cam2_ovl (
        .i_clk  (i_clk     ),
        .i_rst  (i_rst     ),
        .i_en   (i_box_en  ),
        .i_vsync(cam2_vsync),
        .i_de   (cam2_de   ),
        .i_pixel(cam2_pixel),
        .o_vsync(ovl2_vsync),
        .o_de   (ovl2_de   ),
        .o_pixel(ovl2_pixel)
    );

    pack_switch u_switch (
        .i_clk    (i_clk       ),
        .i_rst    (i_rst       ),
        .i_cam_sel(i_cam_sel   ),
        .i_vsync_1(ovl1_vsync  ),
        .i_de_1   (ovl1_de     ),
        .i_pixel_1(ovl1_pixel  ),
        .i_vsync_2(ovl2_vsync  ),
        .i_de_2   (ovl2_de     ),
        .i_pixel_2(ovl2_pixel  ),
        .o_vsync  (o_hdmi_vsync),
        .o_de     (o_hdmi_de   ),
        .o_pixel  (disp_pixel  ),
        .o_cam    (o_cam_shown )
    );

    // Widen to 8 bits per colour by repeating the top bits.
    assign o_hdmi_r = {disp_pixel.r, disp_pixel.r[4:2]};
    assign o_hdmi_g = {disp_pixel.g, disp_pixel.g[5:4]};
    assign o_hdmi_b = {disp_pixel.b, disp_pixel.b[4:2]};

    line_capture u_capture (
        .i_clk      (i_clk       ),
        .i_rst      (i_rst       ),
        .i_vsync    (o_hdmi_vsync),
        .i_de       (o_hdmi_de   ),
        .i_pixel    (disp_pixel  ),
        .i_cam      (o_cam_shown ),
        .i_px_ack   (i_px_ack    ),
        .o_px_req   (o_px_req    ),
        .o_px_data  (o_px_data   ),
        .o_px_cam   (o_px_cam    ),
        .o_px_row   (o_px_row    ),
        .o_px_last  (o_px_last   ),
        .o_frame_err(o_frame_err )
    );

endmodule : aimbot_top

//--- box_overlay.sv
`include "aimbot_params.svh"

module box_overlay #(
    parameter int N_BOX = `AB_N_BOX
) (
    input  logic               i_clk,
    input  logic               i_rst,
    input  logic               i_en,
    input  logic               i_vsync,
    input  logic               i_de,
    input  aimbot_pkg::pixel_t i_pixel,
    output logic               o_vsync,
    output logic               o_de,
    output aimbot_pkg::pixel_t o_pixel
);

    localparam logic [`AB_COL_W-1:0] COL_LAST = `AB_COL_W'(`AB_H_ACT - 1);
    localparam logic [`AB_COL_W-1:0] BOX_W = `AB_COL_W'(`AB_H_ACT / N_BOX);
    localparam logic [`AB_ROW_W-1:0] BOX_H = `AB_ROW_W'(`AB_V_ACT / N_BOX);

    logic [`AB_COL_W-1:0]    col;
    logic [`AB_ROW_W-1:0]    row;
    logic                    on_border;
    aimbot_pkg::video_beat_t beat_d;
    aimbot_pkg::video_beat_t beat_q;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            col <= '0;
            row <= '0;
        end else if (i_vsync) begin
            col <= '0;
            row <= '0;
        end else if (i_de) begin
            if (col == COL_LAST) begin
                col <= '0;
                row <= row + 1'b1;
            end else begin
                col <= col + 1'b1;
            end
        end
    end

    assign on_border = ((col % BOX_W) == '0) || ((row % BOX_H) == '0);

    always_comb begin
        beat_d.vsync = i_vsync;
        beat_d.de    = i_de;
        beat_d.pixel = i_pixel;
        if (i_en && on_border) begin
            beat_d.pixel = `AB_BOX_COLOR;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            beat_q.vsync <= 1'b0;
            beat_q.de    <= 1'b0;
        end else begin
            beat_q <= beat_d;
        end
    end

    assign o_vsync = beat_q.vsync;
    assign o_de    = beat_q.de;
    assign o_pixel = beat_q.pixel;

    // A frame that stops in mid-line would start the next grid on the wrong column.
    a_whole_lines : assert property (@(posedge i_clk) disable iff (i_rst)
        $rose(i_vsync) |-> col == '0);

endmodule : box_overlay

//--- cam_byte_assembler.sv
module cam_byte_assembler (
    input  logic               i_clk,
    input  logic               i_rst,
    input  logic               i_vsync,
    input  logic               i_href,
    input  logic [7:0]         i_data,
    output logic               o_vsync,
    output logic               o_de,
    output aimbot_pkg::pixel_t o_pixel
);

    logic       phase;    // High when the next byte is the low byte.
    logic [7:0] hi_byte;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            phase   <= 1'b0;
            o_vsync <= 1'b0;
            o_de    <= 1'b0;
        end else begin
            o_vsync <= i_vsync;
            o_de    <= i_href && phase;
            if (i_href) begin
                phase <= ~phase;
            end else begin
                phase <= 1'b0;   // Every line starts on a high byte.
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_href && !phase) begin
            hi_byte <= i_data;
        end
        if (i_href && phase) begin
            o_pixel <= {hi_byte, i_data};
        end
    end

    // A line must hold a whole number of pixels.
    a_even_bytes : assert property (@(posedge i_clk) disable iff (i_rst)
        $fell(i_href) |-> !phase);

endmodule : cam_byte_assembler

//--- line_capture.sv
`include "aimbot_params.svh"

module line_capture (
    input  logic                 i_clk,
    input  logic                 i_rst,
    input  logic                 i_vsync,
    input  logic                 i_de,
    input  aimbot_pkg::pixel_t   i_pixel,
    input  logic                 i_cam,
    input  logic                 i_px_ack,
    output logic                 o_px_req,
    output aimbot_pkg::pixel_t   o_px_data,
    output logic                 o_px_cam,
    output logic [`AB_ROW_W-1:0] o_px_row,
    output logic                 o_px_last,
    output logic                 o_frame_err
);

    localparam logic [`AB_COL_W-1:0] COL_LAST = `AB_COL_W'(`AB_H_ACT - 1);

    typedef enum logic [1:0] {
        RD_IDLE,
        RD_REQ,
        RD_REL
    } rd_state_t;

    aimbot_pkg::pixel_t   line_mem [0:1][0:`AB_H_ACT-1];
    logic [1:0]           full;
    logic [`AB_ROW_W-1:0] buf_row [0:1];
    logic [1:0]           buf_cam;

    logic                 wr_buf;
    logic [`AB_COL_W-1:0] wr_col;
    logic [`AB_ROW_W-1:0] wr_row;
    logic                 line_ok;   // The current line found a free buffer.
    logic                 wr_en;
    logic                 wr_last;
    logic                 wr_done;

    logic                 rd_buf;
    logic [`AB_COL_W-1:0] rd_col;
    logic                 rd_load;
    rd_state_t            rd_state;

    // The free check is made once, at the first pixel of a line.
    assign wr_en   = i_de && ((wr_col == '0) ? !full[wr_buf] : line_ok);
    assign wr_last = i_de && (wr_col == COL_LAST);
    assign wr_done = wr_last && wr_en;
    assign rd_load = (rd_state == RD_IDLE) && full[rd_buf];

    always_ff @(posedge i_clk) begin
        if (wr_en) begin
            line_mem[wr_buf][wr_col] <= i_pixel;
        end
        if (wr_done) begin
            buf_row[wr_buf] <= wr_row;
            buf_cam[wr_buf] <= i_cam;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            wr_buf      <= 1'b0;
            wr_col      <= '0;
            wr_row      <= '0;
            line_ok     <= 1'b0;
            o_frame_err <= 1'b0;
        end else if (i_vsync) begin
            wr_col <= '0;
            wr_row <= '0;
        end else if (i_de) begin
            wr_col <= wr_last ? '0 : wr_col + 1'b1;
            if (wr_col == '0) begin
                line_ok <= !full[wr_buf];
            end
            if (wr_last) begin
                wr_row <= wr_row + 1'b1;
                if (wr_en) begin
                    wr_buf <= !wr_buf;
                end else begin
                    o_frame_err <= 1'b1;   // Both buffers were busy, the line is lost.
                end
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            full     <= '0;
            rd_buf   <= 1'b0;
            rd_col   <= '0;
            rd_state <= RD_IDLE;
            o_px_req <= 1'b0;
        end else begin
            if (wr_done) begin
                full[wr_buf] <= 1'b1;
            end
            case (rd_state)
                RD_IDLE: begin
                    if (rd_load) begin
                        o_px_req <= 1'b1;
                        rd_state <= RD_REQ;
                    end
                end
                RD_REQ: begin
                    if (i_px_ack) begin
                        o_px_req <= 1'b0;
                        rd_state <= RD_REL;
                        if (o_px_last) begin
                            full[rd_buf] <= 1'b0;   // Line handed over, buffer is free.
                            rd_buf       <= !rd_buf;
                            rd_col       <= '0;
                        end else begin
                            rd_col <= rd_col + 1'b1;
                        end
                    end
                end
                RD_REL: begin
                    if (!i_px_ack) begin
                        rd_state <= RD_IDLE;
                    end
                end
                default: rd_state <= RD_IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (rd_load) begin
            o_px_data <= line_mem[rd_buf][rd_col];
            o_px_cam  <= buf_cam[rd_buf];
            o_px_row  <= buf_row[rd_buf];
            o_px_last <= (rd_col == COL_LAST);
        end
    end

    a_req_until_ack : assert property (@(posedge i_clk) disable iff (i_rst)
        $fell(o_px_req) |-> $past(i_px_ack));

    a_payload_stable : assert property (@(posedge i_clk) disable iff (i_rst)
        o_px_req && $past(o_px_req)
            |-> $stable({o_px_data, o_px_cam, o_px_row, o_px_last}));

endmodule : line_capture

//--- pack_switch.sv
module pack_switch (
    input  logic               i_clk,
    input  logic               i_rst,
    input  logic               i_cam_sel,
    input  logic               i_vsync_1,
    input  logic               i_de_1,
    input  aimbot_pkg::pixel_t i_pixel_1,
    input  logic               i_vsync_2,
    input  logic               i_de_2,
    input  aimbot_pkg::pixel_t i_pixel_2,
    output logic               o_vsync,
    output logic               o_de,
    output aimbot_pkg::pixel_t o_pixel,
    output logic               o_cam
);

    logic                    sel;       // Zero shows camera 1.
    logic                    sel_next;
    logic                    vs1_prev;
    logic                    vs2_prev;
    logic                    vs_rise;
    aimbot_pkg::video_beat_t beat_1;
    aimbot_pkg::video_beat_t beat_2;
    aimbot_pkg::video_beat_t beat_q;

    assign beat_1 = {i_vsync_1, i_de_1, i_pixel_1};
    assign beat_2 = {i_vsync_2, i_de_2, i_pixel_2};

    // Only the shown stream's frame boundary may change the selection.
    assign vs_rise  = sel ? (i_vsync_2 && !vs2_prev) : (i_vsync_1 && !vs1_prev);
    assign sel_next = vs_rise ? i_cam_sel : sel;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            sel          <= 1'b0;
            vs1_prev     <= 1'b0;
            vs2_prev     <= 1'b0;
            beat_q.vsync <= 1'b0;
            beat_q.de    <= 1'b0;
        end else begin
            sel      <= sel_next;
            vs1_prev <= i_vsync_1;
            vs2_prev <= i_vsync_2;
            beat_q   <= sel_next ? beat_2 : beat_1;   // New camera from the edge on.
        end
    end

    assign o_vsync = beat_q.vsync;
    assign o_de    = beat_q.de;
    assign o_pixel = beat_q.pixel;
    assign o_cam   = sel;

endmodule : pack_switch

//--- run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator, then look for the pass line.
cd "$(dirname "$0")" &&
verilator --binary --assert --timescale 1ns/1ps --top-module tb_aimbot \
    -f sources.f -o sim_aimbot &&
./obj_dir/sim_aimbot 2>&1 | tee /dev/stderr | grep -q "All tests passed" &&
echo "Simulation PASSED" || { echo "Simulation FAILED"; exit 1; }

//--- sources.f
+incdir+.
aimbot_pkg.sv
cam_byte_assembler.sv
box_overlay.sv
pack_switch.sv
line_capture.sv
aimbot_top.sv
tb_aimbot.sv

//--- tb_aimbot.sv
`include "aimbot_params.svh"

module tb_aimbot;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int HBLANK = 120;
    localparam int VBLANK = 300;
    localparam int FRAME_CYC = VBLANK + 8 + `AB_V_ACT * (2 * `AB_H_ACT + HBLANK);
    localparam int LIMIT = 4 * (15 + 4 * FRAME_CYC + VBLANK);

    logic clk = 1'b0;
    logic rst = 1'b1;
    logic cam1_vsync = 1'b1;
    logic cam1_href = 1'b0;
    logic [7:0] cam1_data = 8'h00;
    logic cam2_vsync = 1'b1;
    logic cam2_href = 1'b0;
    logic [7:0] cam2_data = 8'h00;
    logic box_en = 1'b0;
    logic cam_sel = 1'b0;
    logic px_ack = 1'b0;
    logic o_hdmi_vsync, o_hdmi_de, o_cam_shown, o_px_req, o_px_cam, o_px_last, o_frame_err;
    logic [7:0] o_hdmi_r, o_hdmi_g, o_hdmi_b;
    logic [`AB_ROW_W-1:0] o_px_row;
    aimbot_pkg::pixel_t o_px_data;

    logic pix_sent = 1'b0;     // High while the second byte of a pixel is on the bus.
    logic stall = 1'b0;
    logic fast = 1'b0;
    logic err_allowed = 1'b0;
    logic exp_cam = 1'b0;
    logic [15:0] cam_lfsr = 16'd36712;
    logic [15:0] rd_lfsr = 16'd36712;
    logic [23:0] disp_exp;
    logic [20:0] line_exp;     // Camera, row, last flag and pixel of one transfer.
    logic [23:0] disp_q[$];
    logic [20:0] line_q[$];
    int wait_cnt = 0;
    int cycles = 0;

    aimbot_top dut_i (
        .i_clk(clk), .i_rst(rst),
        .i_cam1_vsync(cam1_vsync), .i_cam1_href(cam1_href), .i_cam1_data(cam1_data),
        .i_cam2_vsync(cam2_vsync), .i_cam2_href(cam2_href), .i_cam2_data(cam2_data),
        .i_box_en(box_en), .i_cam_sel(cam_sel), .i_px_ack(px_ack),
        .o_hdmi_vsync(o_hdmi_vsync), .o_hdmi_de(o_hdmi_de), .o_hdmi_r(o_hdmi_r),
        .o_hdmi_g(o_hdmi_g), .o_hdmi_b(o_hdmi_b), .o_cam_shown(o_cam_shown),
        .o_px_req(o_px_req), .o_px_data(o_px_data), .o_px_cam(o_px_cam),
        .o_px_row(o_px_row), .o_px_last(o_px_last), .o_frame_err(o_frame_err)
    );

    always #4 clk = ~clk;

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};   // Taps 16, 14, 13, 11.
    endfunction

    function automatic logic [23:0] widen(input logic [15:0] p);
        return {p[15:11], p[15:13], p[10:5], p[10:9], p[4:0], p[4:2]};
    endfunction

    task automatic report_error(input string msg);
        $display("[FAIL] %0t %s", $time, msg);
        $display("Some tests failed");
        $fatal(1);
    endtask

    // Both cameras run in lockstep; the shown one is fixed at the frame start.
    task automatic drive_frame(input logic box_on, input logic next_sel, input logic stall_frame);
        logic [15:0] p1;
        logic [15:0] p2;
        logic [15:0] shown;
        exp_cam = cam_sel;
        if (stall_frame) begin
            err_allowed = 1'b1;
        end
        box_en <= box_on;
        cam1_vsync <= 1'b1;
        cam2_vsync <= 1'b1;
        repeat (VBLANK) @(posedge clk);
        cam1_vsync <= 1'b0;
        cam2_vsync <= 1'b0;
        stall <= stall_frame;
        repeat (8) @(posedge clk);
        for (int row = 0; row < `AB_V_ACT; row++) begin
            if (row == 4) begin
                cam_sel <= next_sel;   // The request lands mid-frame and is shown next frame.
            end
            for (int col = 0; col < `AB_H_ACT; col++) begin
                repeat (16) cam_lfsr = lfsr_step(cam_lfsr);
                p1 = cam_lfsr;
                repeat (16) cam_lfsr = lfsr_step(cam_lfsr);
                p2 = cam_lfsr;
                shown = exp_cam ? p2 : p1;
                if (box_on && ((col % (`AB_H_ACT / `AB_N_BOX) == 0)
                        || (row % (`AB_V_ACT / `AB_N_BOX) == 0))) begin
                    shown = `AB_BOX_COLOR;
                end
                disp_q.push_back(widen(shown));
                if (!(stall_frame && row == 2)) begin   // Third stalled line is lost.
                    line_q.push_back({exp_cam, 3'(row), col == `AB_H_ACT - 1, shown});
                end
                cam1_href <= 1'b1;
                cam2_href <= 1'b1;
                cam1_data <= p1[15:8];
                cam2_data <= p2[15:8];
                pix_sent <= 1'b0;
                @(posedge clk);
                cam1_data <= p1[7:0];
                cam2_data <= p2[7:0];
                pix_sent <= 1'b1;
                @(posedge clk);
            end
            cam1_href <= 1'b0;
            cam2_href <= 1'b0;
            pix_sent <= 1'b0;
            if (stall_frame && row == 2) begin
                stall <= 1'b0;
                fast <= 1'b1;
            end
            repeat (HBLANK) @(posedge clk);
        end
    endtask

    always @(posedge clk) begin
        if (!rst && o_hdmi_de) begin
            if (disp_q.size() == 0) begin
                report_error("display beat arrived with no pixel expected");
            end else begin
                disp_exp = disp_q.pop_front();
                assert ({o_hdmi_r, o_hdmi_g, o_hdmi_b} == disp_exp) else report_error(
                    $sformatf("display pixel %h, expected %h",
                        {o_hdmi_r, o_hdmi_g, o_hdmi_b}, disp_exp));
            end
        end
    end

    // Line reader on the export port that acks after a random wait.
    always @(posedge clk) begin
        if (rst) begin
            px_ack <= 1'b0;
            wait_cnt <= 0;
        end else if (!px_ack && o_px_req && !stall) begin
            if (wait_cnt > 0) begin
                wait_cnt <= wait_cnt - 1;
            end else begin
                if (line_q.size() == 0) begin
                    report_error("export transfer arrived with no line expected");
                end else begin
                    line_exp = line_q.pop_front();
                    assert ({o_px_cam, o_px_row, o_px_last, o_px_data} == line_exp)
                        else report_error($sformatf("export %h, expected %h",
                            {o_px_cam, o_px_row, o_px_last, o_px_data}, line_exp));
                end
                rd_lfsr = lfsr_step(lfsr_step(rd_lfsr));
                wait_cnt <= fast ? 0 : int'(rd_lfsr[1:0]);
                px_ack <= 1'b1;
            end
        end else if (px_ack && !o_px_req) begin
            px_ack <= 1'b0;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", LIMIT);
            $display("Some tests failed");
            $fatal(1);
        end
    end

    a_reset_values : assert property (@(posedge clk) $fell(rst)
        |-> !o_px_req && !o_hdmi_de && !o_frame_err && !o_cam_shown)
        else report_error("outputs were not cleared by reset");
    a_de_timing : assert property (@(posedge clk) disable iff (rst)
        o_hdmi_de == $past(pix_sent, 3))
        else report_error("display beat not 3 cycles after its second byte");
    a_vsync_timing : assert property (@(posedge clk) disable iff (rst)
        !$past(rst, 3) |-> o_hdmi_vsync == $past(cam1_vsync, 3))
        else report_error("display vsync not 3 cycles after the camera vsync");
    a_shown_cam : assert property (@(posedge clk) disable iff (rst)
        o_hdmi_de |-> o_cam_shown == exp_cam)
        else report_error("wrong camera shown on the display");
    a_switch_at_vsync : assert property (@(posedge clk) disable iff (rst)
        !o_hdmi_vsync |-> $stable(o_cam_shown))
        else report_error("shown camera changed outside vertical blanking");
    a_req_after_release : assert property (@(posedge clk) disable iff (rst)
        $rose(o_px_req) |-> !$past(px_ack))
        else report_error("export request rose before ack was released");
    a_err_sticky : assert property (@(posedge clk) disable iff (rst)
        $past(o_frame_err) |-> o_frame_err)
        else report_error("frame error flag fell before reset");
    a_err_cause : assert property (@(posedge clk) disable iff (rst)
        !err_allowed |-> !o_frame_err)
        else report_error("frame error raised without a reader stall");

    initial begin
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        repeat (5) @(posedge clk);
        drive_frame(1'b0, 1'b1, 1'b0);
        drive_frame(1'b1, 1'b0, 1'b0);
        drive_frame(1'b1, 1'b0, 1'b0);
        drive_frame(1'b0, 1'b0, 1'b1);
        cam1_vsync <= 1'b1;
        cam2_vsync <= 1'b1;
        while (disp_q.size() != 0 || line_q.size() != 0) begin
            @(posedge clk);
        end
        if (o_frame_err) begin
            $display("All tests passed");
            $finish;
        end else begin
            report_error("frame error flag was not set at the end");
        end
    end

endmodule : tb_aimbot
